// ==== logic/mtx_phase_acc.sv ====
`timescale 1ns/1ps

module mtx_phase_acc (
  input  logic                            clk,
  input  logic                            reset,
  input  mtx_pkg::ph_cmd_t                cmd,
  input  logic                            cmd_valid,
  output logic [mtx_pkg::PHASE_WIDTH-1:0] phase,
  output logic                            phase_valid,
  output logic                            last_in_symbol,
  output logic                            last_in_frame
);

  logic [mtx_pkg::PHASE_WIDTH-1:0] ph_inc;       // per-sample step of current symbol
  logic [mtx_pkg::PHASE_WIDTH-1:0] start_phase;  // start phase of next symbol

  always_ff @(posedge clk) begin
    if (reset) begin
      phase       <= mtx_pkg::START_PH;
      ph_inc      <= mtx_pkg::START_PH_INC;
      start_phase <= mtx_pkg::START_PH - mtx_pkg::NPH_SHIFT;
      phase_valid <= 1'b0;
    end else begin
      phase_valid <= 1'b0;
      if (cmd_valid) begin
        case (cmd.op)
          mtx_pkg::PH_STEP: begin
            phase       <= phase + ph_inc;  // wraps mod 2^24
            phase_valid <= 1'b1;
          end
          mtx_pkg::PH_NEXT_SYMBOL: begin
            phase       <= start_phase;
            ph_inc      <= ph_inc + mtx_pkg::DPH_INC;  // one tone step up
            start_phase <= start_phase - mtx_pkg::NPH_SHIFT;
            phase_valid <= 1'b1;
          end
          mtx_pkg::PH_NEW_FRAME: begin
            phase       <= mtx_pkg::START_PH;
            ph_inc      <= mtx_pkg::START_PH_INC;
            start_phase <= mtx_pkg::START_PH - mtx_pkg::NPH_SHIFT;
            phase_valid <= 1'b1;
          end
          default: begin
            phase_valid <= 1'b0;  // hold keeps all registers
          end
        endcase
      end
    end
  end

  // flags ride with the phase
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      last_in_symbol <= cmd.last_in_symbol;
      last_in_frame  <= cmd.last_in_frame;
    end
  end

endmodule

// ==== logic/mtx_pkg.sv ====
package mtx_pkg;

  // phase and sample widths
  localparam int PHASE_WIDTH    = 24;
  localparam int SAMPLE_WIDTH   = 16;                // two's complement sin/cos
  localparam int LUT_ADDR_WIDTH = 8;                 // quarter table address bits
  localparam int LUT_DATA_WIDTH = SAMPLE_WIDTH - 1;  // unsigned magnitude
  localparam int LUT_DEPTH      = 1 << LUT_ADDR_WIDTH;
  localparam int LUT_AMPL       = 32767;
  localparam real LUT_PI        = 3.14159265358979;

  // quarter table entry i = round(32767 * sin(pi/2 * (i + 0.5) / 256))
  // the half-step offset keeps the mirrored cosine read exact

  // frame shape
  localparam int NUM_SYMBOLS        = 16;
  localparam int SAMPLES_PER_SYMBOL = 1280;
  localparam int SAMPLE_CNT_WIDTH   = $clog2(SAMPLES_PER_SYMBOL);
  localparam int SYMBOL_CNT_WIDTH   = $clog2(NUM_SYMBOLS);
  localparam logic [SAMPLE_CNT_WIDTH-1:0] LAST_SAMPLE =
    SAMPLE_CNT_WIDTH'(SAMPLES_PER_SYMBOL - 1);
  localparam logic [SYMBOL_CNT_WIDTH-1:0] LAST_SYMBOL =
    SYMBOL_CNT_WIDTH'(NUM_SYMBOLS - 1);

  // tone parameters
  localparam logic [PHASE_WIDTH-1:0] START_PH     = (1 << (PHASE_WIDTH - 1))
                                                  + (1 << (PHASE_WIDTH - 2));
  localparam logic [PHASE_WIDTH-1:0] NPH_SHIFT    = 1 << (PHASE_WIDTH - 2);
  localparam logic [PHASE_WIDTH-1:0] START_PH_INC = 16384;
  localparam logic [PHASE_WIDTH-1:0] DPH_INC      = 16384;

  // credit port
  localparam int CREDIT_WIDTH = 4;
  localparam logic [CREDIT_WIDTH-1:0] INIT_CREDITS = 4'd8;  // receiver buffer depth

  typedef enum logic [1:0] {
    PH_HOLD        = 2'd0,
    PH_STEP        = 2'd1,
    PH_NEXT_SYMBOL = 2'd2,
    PH_NEW_FRAME   = 2'd3
  } ph_op_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } seq_state_e;

  typedef struct packed {
    ph_op_e op;
    logic   last_in_symbol;
    logic   last_in_frame;
  } ph_cmd_t;

  typedef struct packed {
    logic [SAMPLE_WIDTH-1:0] sin;
    logic [SAMPLE_WIDTH-1:0] cos;
    logic                    last_in_symbol;
    logic                    last_in_frame;
  } mtx_sample_t;

endpackage

// ==== logic/mtx_seq_ctrl.sv ====
`timescale 1ns/1ps

module mtx_seq_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  logic             run,
  input  logic             credit_return,
  output mtx_pkg::ph_cmd_t cmd,
  output logic             cmd_valid,
  output logic             busy
);

  mtx_pkg::seq_state_e                     state;
  logic [mtx_pkg::SAMPLE_CNT_WIDTH-1:0]    sample_cnt;
  logic [mtx_pkg::SYMBOL_CNT_WIDTH-1:0]    symbol_cnt;
  logic [mtx_pkg::CREDIT_WIDTH-1:0]        credits;
  logic                                    issue;
  logic                                    last_in_symbol;
  logic                                    last_in_frame;

  assign issue          = (state == mtx_pkg::ST_RUN) && (credits != '0);
  assign last_in_symbol = (sample_cnt == mtx_pkg::LAST_SAMPLE);
  assign last_in_frame  = last_in_symbol && (symbol_cnt == mtx_pkg::LAST_SYMBOL);

  // opcode per issued sample
  always_comb begin
    cmd.op = mtx_pkg::PH_HOLD;
    if (issue) begin
      if (sample_cnt != '0) begin
        cmd.op = mtx_pkg::PH_STEP;
      end else if (symbol_cnt == '0) begin
        cmd.op = mtx_pkg::PH_NEW_FRAME;
      end else begin
        cmd.op = mtx_pkg::PH_NEXT_SYMBOL;
      end
    end
    cmd.last_in_symbol = issue && last_in_symbol;
    cmd.last_in_frame  = issue && last_in_frame;
  end

  assign cmd_valid = issue;
  assign busy      = (state == mtx_pkg::ST_RUN);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= mtx_pkg::ST_IDLE;
      sample_cnt <= '0;
      symbol_cnt <= '0;
    end else begin
      case (state)
        mtx_pkg::ST_IDLE: begin
          if (run) begin
            state <= mtx_pkg::ST_RUN;  // counters already at frame start
          end
        end
        mtx_pkg::ST_RUN: begin
          if (issue) begin
            if (last_in_symbol) begin
              sample_cnt <= '0;
              if (last_in_frame) begin
                symbol_cnt <= '0;
                if (!run) begin
                  state <= mtx_pkg::ST_IDLE;  // stop only at frame end
                end
              end else begin
                symbol_cnt <= symbol_cnt + 1'b1;
              end
            end else begin
              sample_cnt <= sample_cnt + 1'b1;
            end
          end
        end
        default: state <= mtx_pkg::ST_IDLE;
      endcase
    end
  end

  // one credit spent per issue, one regained per return
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= mtx_pkg::INIT_CREDITS;
    end else if (issue && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (!issue && credit_return) begin
      credits <= credits + 1'b1;
    end
  end

  // the receiver can never hand back more than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (reset)
    credits <= mtx_pkg::INIT_CREDITS
  ) else $error("credit count above INIT_CREDITS");

  a_no_return_when_full: assert property (
    @(posedge clk) disable iff (reset)
    credit_return |-> (credits != mtx_pkg::INIT_CREDITS)
  ) else $error("credit_return with no sample outstanding");

endmodule

// ==== logic/mtx_sig_gen.sv ====
`timescale 1ns/1ps

module mtx_sig_gen (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 run,
  input  logic                 credit_return,
  output mtx_pkg::mtx_sample_t sample,
  output logic                 sample_valid,
  output logic                 busy
);

  mtx_pkg::ph_cmd_t                cmd;
  logic                            cmd_valid;
  logic [mtx_pkg::PHASE_WIDTH-1:0] phase;
  logic                            phase_valid;
  logic                            last_in_symbol;
  logic                            last_in_frame;

  // frame sequencing and credit flow
  mtx_seq_ctrl i_seq_ctrl (
    .clk           (clk),
    .reset         (reset),
    .run           (run),
    .credit_return (credit_return),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .busy          (busy)
  );

  mtx_phase_acc i_phase_acc (
    .clk            (clk),
    .reset          (reset),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .phase          (phase),
    .phase_valid    (phase_valid),
    .last_in_symbol (last_in_symbol),
    .last_in_frame  (last_in_frame)
  );

  // phase to sin/cos, two cycles
  mtx_sin_cos_lut i_sin_cos_lut (
    .clk            (clk),
    .reset          (reset),
    .phase          (phase),
    .phase_valid    (phase_valid),
    .last_in_symbol (last_in_symbol),
    .last_in_frame  (last_in_frame),
    .sample         (sample),
    .sample_valid   (sample_valid)
  );

endmodule

// ==== logic/mtx_sin_cos_lut.sv ====
`timescale 1ns/1ps

module mtx_sin_cos_lut (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mtx_pkg::PHASE_WIDTH-1:0] phase,
  input  logic                            phase_valid,
  input  logic                            last_in_symbol,
  input  logic                            last_in_frame,
  output mtx_pkg::mtx_sample_t            sample,
  output logic                            sample_valid
);

  logic [1:0]                         quadrant;
  logic [mtx_pkg::LUT_ADDR_WIDTH-1:0] offset;
  logic [mtx_pkg::LUT_ADDR_WIDTH-1:0] sin_addr;
  logic [mtx_pkg::LUT_ADDR_WIDTH-1:0] cos_addr;
  logic [mtx_pkg::LUT_DATA_WIDTH-1:0] sin_mag;
  logic [mtx_pkg::LUT_DATA_WIDTH-1:0] cos_mag;
  logic [mtx_pkg::SAMPLE_WIDTH-1:0]   sin_pos;
  logic [mtx_pkg::SAMPLE_WIDTH-1:0]   cos_pos;

  // stage 1 control, lines up with the ROM output
  logic [1:0] quadrant_d;
  logic       valid_d;
  logic       last_in_symbol_d;
  logic       last_in_frame_d;

  assign quadrant = phase[mtx_pkg::PHASE_WIDTH-1 -: 2];
  assign offset   = phase[mtx_pkg::PHASE_WIDTH-3 -: mtx_pkg::LUT_ADDR_WIDTH];

  // odd quadrants run the table backwards
  assign sin_addr = quadrant[0] ? ~offset : offset;
  assign cos_addr = ~sin_addr;  // cos(x) = sin(pi/2 - x)

  mtx_sine_rom i_sine_rom (
    .clk    (clk),
    .addr_a (sin_addr),
    .addr_b (cos_addr),
    .data_a (sin_mag),
    .data_b (cos_mag)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= phase_valid;
    end
  end

  always_ff @(posedge clk) begin
    quadrant_d       <= quadrant;
    last_in_symbol_d <= last_in_symbol;
    last_in_frame_d  <= last_in_frame;
  end

  assign sin_pos = {1'b0, sin_mag};
  assign cos_pos = {1'b0, cos_mag};

  // sin negative in q2/q3, cos negative in q1/q2
  always_ff @(posedge clk) begin
    sample.sin            <= quadrant_d[1] ? -sin_pos : sin_pos;
    sample.cos            <= (quadrant_d[1] ^ quadrant_d[0]) ? -cos_pos : cos_pos;
    sample.last_in_symbol <= last_in_symbol_d;
    sample.last_in_frame  <= last_in_frame_d;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= valid_d;
    end
  end

  // ROM read plus fold register
  a_lut_latency: assert property (
    @(posedge clk) disable iff (reset)
    sample_valid == $past(phase_valid, 2)
  ) else $error("sample_valid does not trail phase_valid by 2 cycles");

endmodule

// ==== logic/mtx_sine_rom.sv ====
`timescale 1ns/1ps

module mtx_sine_rom (
  input  logic                               clk,
  input  logic [mtx_pkg::LUT_ADDR_WIDTH-1:0] addr_a,
  input  logic [mtx_pkg::LUT_ADDR_WIDTH-1:0] addr_b,
  output logic [mtx_pkg::LUT_DATA_WIDTH-1:0] data_a,
  output logic [mtx_pkg::LUT_DATA_WIDTH-1:0] data_b
);

  logic [mtx_pkg::LUT_DATA_WIDTH-1:0] table_q [mtx_pkg::LUT_DEPTH];

  // quarter wave, sampled at the middle of each step
  initial begin
    real angle;
    int  entry;
    for (int i = 0; i < mtx_pkg::LUT_DEPTH; i++) begin
      angle = mtx_pkg::LUT_PI / 2.0 * (real'(i) + 0.5) / real'(mtx_pkg::LUT_DEPTH);
      entry = $rtoi(real'(mtx_pkg::LUT_AMPL) * $sin(angle) + 0.5);  // round half up
      table_q[i] = entry[mtx_pkg::LUT_DATA_WIDTH-1:0];
    end
  end

  // two independent read ports, one cycle latency
  always_ff @(posedge clk) begin
    data_a <= table_q[addr_a];
    data_b <= table_q[addr_b];
  end

endmodule

// ==== mtx_sig_gen.f ====
+incdir+test
logic/mtx_pkg.sv
logic/mtx_sine_rom.sv
logic/mtx_sin_cos_lut.sv
logic/mtx_phase_acc.sv
logic/mtx_seq_ctrl.sv
logic/mtx_sig_gen.sv
test/tb_mtx_sig_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the mtx_sig_gen testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mtx_sig_gen \
  -f mtx_sig_gen.f \
  -o sim_tb_mtx_sig_gen

./obj_dir/sim_tb_mtx_sig_gen | tee sim.log

# the log decides, not the simulator's exit status
if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== test/mtx_ref_model.svh ====
`ifndef MTX_REF_MODEL_SVH
`define MTX_REF_MODEL_SVH

// samples in one frame
function automatic int frame_length();
  return mtx_pkg::NUM_SYMBOLS * mtx_pkg::SAMPLES_PER_SYMBOL;
endfunction

// entry i = round(32767 * sin(pi/2 * (i + 0.5) / 256))
function automatic logic [mtx_pkg::SAMPLE_WIDTH-1:0] table_entry(input int i);
  real angle;
  int  value;
  angle = 3.14159265358979 / 2.0 * (real'(i) + 0.5) / real'(mtx_pkg::LUT_DEPTH);
  value = $rtoi(32767.0 * $sin(angle) + 0.5);
  return mtx_pkg::SAMPLE_WIDTH'(value);
endfunction

// phase of sample n in symbol k, modulo one turn
function automatic logic [mtx_pkg::PHASE_WIDTH-1:0] expected_phase(input int k, input int n);
  logic [31:0] start;
  logic [31:0] inc;
  logic [31:0] ph;
  start = 32'(mtx_pkg::START_PH) - 32'(k) * 32'(mtx_pkg::NPH_SHIFT);  // rotated start
  inc   = 32'(mtx_pkg::START_PH_INC) + 32'(k) * 32'(mtx_pkg::DPH_INC);  // one tone up
  ph    = start + 32'(n) * inc;
  return ph[mtx_pkg::PHASE_WIDTH-1:0];
endfunction

// sine value at position offset inside quadrant q
function automatic logic [mtx_pkg::SAMPLE_WIDTH-1:0] quarter_value(input int q, input int offset);
  int mirror;
  mirror = mtx_pkg::LUT_DEPTH - 1 - offset;
  case (q % 4)
    0: return table_entry(offset);         // rising to peak
    1: return table_entry(mirror);         // falling to zero
    2: return -table_entry(offset);        // falling to trough
    default: return -table_entry(mirror);  // rising to zero
  endcase
endfunction

function automatic mtx_pkg::mtx_sample_t expected_sample(input int k, input int n);
  mtx_pkg::mtx_sample_t            s;
  logic [mtx_pkg::PHASE_WIDTH-1:0] ph;
  int                              q;
  int                              offset;
  ph               = expected_phase(k, n);
  q                = int'(ph[mtx_pkg::PHASE_WIDTH-1 -: 2]);
  offset           = int'(ph[mtx_pkg::PHASE_WIDTH-3 -: mtx_pkg::LUT_ADDR_WIDTH]);
  s.sin            = quarter_value(q, offset);
  s.cos            = quarter_value(q + 1, offset);  // cos leads sin by a quarter turn
  s.last_in_symbol = (n == mtx_pkg::SAMPLES_PER_SYMBOL - 1);
  s.last_in_frame  = s.last_in_symbol && (k == mtx_pkg::NUM_SYMBOLS - 1);
  return s;
endfunction

`endif

// ==== test/tb_mtx_sig_gen.sv ====
`timescale 1ns/1ps

module tb_mtx_sig_gen;

  `include "mtx_ref_model.svh"

  typedef enum int {DRAIN_NOW, DRAIN_RANDOM, DRAIN_NONE} drain_e;

  logic                 clk;
  logic                 reset;
  logic                 run;
  logic                 credit_return = 1'b0;
  mtx_pkg::mtx_sample_t sample;
  logic                 sample_valid;
  logic                 busy;

  drain_e               drain_mode = DRAIN_NOW;
  mtx_pkg::mtx_sample_t rx_queue[$];       // receiver buffer
  mtx_pkg::mtx_sample_t expected;
  logic                 drain;
  int                   stall_left = 0;
  int                   exp_k = 0;         // symbol of next expected sample
  int                   exp_n = 0;         // sample within that symbol
  int                   sample_total = 0;
  int                   sym_last_total = 0;
  int                   frame_last_total = 0;
  int                   stream_errors = 0;
  int                   stream_checks = 0;
  int                   errors;
  int                   checks;
  int                   errors_before;
  int                   base;
  int                   sym_base;
  int                   frame_base;

  mtx_sig_gen i_dut (
    .clk           (clk),
    .reset         (reset),
    .run           (run),
    .credit_return (credit_return),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .busy          (busy)
  );

  always #50 clk = ~clk;

  task automatic check_sample(input mtx_pkg::mtx_sample_t got, input mtx_pkg::mtx_sample_t want,
                              input int k, input int n);
    stream_checks++;
    if (got.sin !== want.sin) begin
      $display("[ERROR] sample.sin k=%0d n=%0d got %h expected %h", k, n, got.sin, want.sin);
      stream_errors++;
    end
    if (got.cos !== want.cos) begin
      $display("[ERROR] sample.cos k=%0d n=%0d got %h expected %h", k, n, got.cos, want.cos);
      stream_errors++;
    end
    if (got.last_in_symbol !== want.last_in_symbol) begin
      $display("[ERROR] sample.last_in_symbol k=%0d n=%0d got %h expected %h", k, n,
               got.last_in_symbol, want.last_in_symbol);
      stream_errors++;
    end
    if (got.last_in_frame !== want.last_in_frame) begin
      $display("[ERROR] sample.last_in_frame k=%0d n=%0d got %h expected %h", k, n,
               got.last_in_frame, want.last_in_frame);
      stream_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("[ERROR] %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  // compare every valid sample, then hand it to the receiver
  always @(posedge clk) begin
    if (!reset && sample_valid) begin
      expected = expected_sample(exp_k, exp_n);
      check_sample(sample, expected, exp_k, exp_n);
      sample_total++;
      if (sample.last_in_symbol) begin
        sym_last_total++;
      end
      if (sample.last_in_frame) begin
        frame_last_total++;
      end
      if (exp_n == mtx_pkg::SAMPLES_PER_SYMBOL - 1) begin
        exp_n = 0;
        exp_k = (exp_k == mtx_pkg::NUM_SYMBOLS - 1) ? 0 : exp_k + 1;
      end else begin
        exp_n++;
      end
      if (rx_queue.size() >= int'(mtx_pkg::INIT_CREDITS)) begin
        $display("receiver overflow: a sample arrived with %0d already held", rx_queue.size());
        stream_errors++;
      end else begin
        rx_queue.push_back(sample);
      end
    end
  end

  // receiver drains at most one entry per cycle and returns its credit
  always @(negedge clk) begin
    drain = 1'b0;
    if (!reset && rx_queue.size() > 0) begin
      case (drain_mode)
        DRAIN_NOW: drain = 1'b1;
        DRAIN_RANDOM: begin
          if (stall_left > 0) begin
            stall_left--;
          end else if ($urandom_range(47, 0) == 0) begin
            stall_left = $urandom_range(90, 20);  // long stall
          end else begin
            drain = ($urandom_range(1, 0) == 1);
          end
        end
        default: drain = 1'b0;
      endcase
    end
    if (drain) begin
      void'(rx_queue.pop_front());
    end
    credit_return = drain;
  end

  task automatic wait_for_samples(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (sample_total < target && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (sample_total < target) begin
      $display("timeout: %0d samples arrived, %0d were expected", sample_total, target);
      errors++;
    end
  endtask

  task automatic start_run(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    run = 1'b1;
    while (!busy && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!busy) begin
      $display("timeout: busy never rose after run was set");
      errors++;
    end
  endtask

  // drop run, let the frame finish and make sure nothing follows it
  task automatic stop_after_frame(input int target, input int limit);
    int cycles;
    cycles = 0;
    run = 1'b0;
    while (busy && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("timeout: busy stayed high after run was dropped");
      errors++;
    end
    wait_for_samples(target, limit);
    repeat (20) @(negedge clk);
    check_count("samples at frame end", 32'(sample_total), 32'(target));
  endtask

  task automatic finish_test(input string name);
    if (errors + stream_errors == errors_before) begin
      $display("%-32s ok", name);
    end else begin
      $display("%-32s failed", name);
    end
    errors_before = errors + stream_errors;
  endtask

  initial begin
    void'($urandom(32'h389b_793c));
    clk           = 1'b0;
    reset         = 1'b1;
    run           = 1'b0;
    errors        = 0;
    checks        = 0;
    errors_before = 0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    repeat (20) begin
      @(negedge clk);
      check_count("sample_valid while idle", 32'(sample_valid), 32'd0);
      check_count("busy while idle", 32'(busy), 32'd0);
    end
    check_count("samples while idle", 32'(sample_total), 32'd0);
    finish_test("idle after reset");

    base       = sample_total;
    sym_base   = sym_last_total;
    frame_base = frame_last_total;
    start_run(10);
    stop_after_frame(base + frame_length(), 4 * frame_length());
    finish_test("full frame, immediate credits");
    check_count("last_in_symbol count", 32'(sym_last_total - sym_base), mtx_pkg::NUM_SYMBOLS);
    check_count("last_in_frame count", 32'(frame_last_total - frame_base), 32'd1);
    finish_test("symbol and frame flags");

    drain_mode = DRAIN_RANDOM;
    base       = sample_total;
    start_run(10);
    stop_after_frame(base + frame_length(), 20 * frame_length());
    drain_mode = DRAIN_NOW;
    finish_test("random credit return");

    base = sample_total;
    start_run(10);
    wait_for_samples(base + 5000, 4 * frame_length());
    stop_after_frame(base + frame_length(), 4 * frame_length());
    base = sample_total;
    start_run(10);
    wait_for_samples(base + 3, 100);  // first samples checked against symbol 0
    stop_after_frame(base + frame_length(), 4 * frame_length());
    finish_test("run dropped mid-frame");

    drain_mode = DRAIN_NONE;
    base       = sample_total;
    start_run(10);
    wait_for_samples(base + int'(mtx_pkg::INIT_CREDITS), 100);
    repeat (40) @(negedge clk);
    check_count("samples with credits withheld", 32'(sample_total - base),
                32'(mtx_pkg::INIT_CREDITS));
    drain_mode = DRAIN_NOW;
    wait_for_samples(base + int'(mtx_pkg::INIT_CREDITS) + 1, 100);
    stop_after_frame(base + frame_length(), 4 * frame_length());
    finish_test("credits withheld");

    $display("checks: %0d, errors: %0d", checks + stream_checks, errors + stream_errors);
    if (errors + stream_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
